//--- rtl/ndn_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes for the FIB, shared by the package and the queues
// Prefix width must be a whole multiple of the hash width
// Table size is 2**(len width + hash width) bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef NDN_SETTINGS_SVH
`define NDN_SETTINGS_SVH

// Name prefix in bits
`define NDN_PREFIX_W 64
// Prefix length, 0 to 63 leading bits
`define NDN_LEN_W 6
// Bucket index, 256 buckets per length
`define NDN_HASH_W 8
// Requester face id
`define NDN_TAG_W 4
// Entries per request queue
`define NDN_FIFO_DEPTH 4

`endif

//--- rtl/ndn_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared across the FIB
// Field order of the queue entries is fixed, prefix on top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "ndn_settings.svh"

package ndn_pkg;

    typedef logic [`NDN_PREFIX_W-1:0] prefix_t;
    typedef logic [`NDN_LEN_W-1:0]    len_t;
    typedef logic [`NDN_HASH_W-1:0]   hash_t;
    typedef logic [`NDN_TAG_W-1:0]    tag_t;

    // Insert queue entry, 70 bits
    typedef struct packed {
        prefix_t prefix;
        len_t    len;
    } fib_key_t;

    // Lookup queue entry, 74 bits
    typedef struct packed {
        prefix_t prefix;
        len_t    len;
        tag_t    tag;
    } fib_lkp_t;

endpackage

`default_nettype wire

//--- rtl/prefix_hash.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Masks a prefix to its leading bits and folds it to a hash
// Both results appear one cycle after the inputs
// Length 0 gives the all-zero default route
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module prefix_hash (
    input  logic             clk,
    input  logic             rst,
    input  ndn_pkg::prefix_t hash_prefix,
    input  ndn_pkg::len_t    hash_len,
    output ndn_pkg::hash_t   hash_value,
    output ndn_pkg::prefix_t masked_prefix
);
    import ndn_pkg::*;

    localparam int HASH_W = $bits(hash_t);
    localparam int N_CHUNK = $bits(prefix_t) / HASH_W;
    localparam prefix_t ALL_ONES = '1;

    prefix_t mask_c;
    prefix_t masked_c;
    hash_t   fold_c;

    always_comb begin
        // Top len bits kept, a shift by 0 keeps none
        mask_c = ~(ALL_ONES >> hash_len);
        masked_c = hash_prefix & mask_c;
        // Seed with the length so equal masks at other lengths spread out
        fold_c = hash_t'(hash_len);
        for (int i = 0; i < N_CHUNK; i++) begin
            fold_c = fold_c ^ masked_c[i*HASH_W +: HASH_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hash_value    <= '0;
            masked_prefix <= '0;
        end else begin
            hash_value    <= fold_c;
            masked_prefix <= masked_c;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fib_valid_table.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Valid-bit store, one bit per (length, hash) pair
// Entries that share a length and hash alias by design
// After reset a sweep zeroes all bits, about 16k cycles
// Callers must hold off reads and writes while clear_busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fib_valid_table (
    input  logic           clk,
    input  logic           rst,
    input  logic           wr_en,
    input  ndn_pkg::len_t  wr_len,
    input  ndn_pkg::hash_t wr_hash,
    input  logic           rd_en,
    input  ndn_pkg::len_t  rd_len,
    input  ndn_pkg::hash_t rd_hash,
    output logic           rd_bit,
    output logic           clear_busy
);
    import ndn_pkg::*;

    localparam int ADDR_W = $bits(len_t) + $bits(hash_t);
    localparam int DEPTH = 2 ** ADDR_W;

    logic              valid_mem [DEPTH];
    logic [ADDR_W-1:0] clr_addr;
    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // Length selects the row, hash the bucket
    assign wr_addr = {wr_len, wr_hash};
    assign rd_addr = {rd_len, rd_hash};

    // Sweep counter, busy until the last address is cleared
    always_ff @(posedge clk) begin
        if (rst) begin
            clr_addr   <= '0;
            clear_busy <= 1'b1;
        end else if (clear_busy) begin
            clr_addr <= clr_addr + 1'b1;
            if (&clr_addr) begin
                clear_busy <= 1'b0;
            end
        end
    end

    // Sweep owns the write port while it runs
    always_ff @(posedge clk) begin
        if (clear_busy) begin
            valid_mem[clr_addr] <= 1'b0;
        end else if (wr_en) begin
            valid_mem[wr_addr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_bit <= valid_mem[rd_addr];
        end
    end

    // Controller must stay off the table until the sweep is over
    a_no_access_in_clear: assert property (
        @(posedge clk) disable iff (rst) clear_busy |-> !(wr_en || rd_en)
    ) else $error("table access during clear sweep");

endmodule

`default_nettype wire

//--- rtl/req_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Request queue with valid/ready on both sides
// in_ready is registered, so it is low during reset
// A push shows at out_valid on the following cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "ndn_settings.svh"

module req_fifo #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   in_valid,
    output logic   in_ready,
    input  entry_t in_data,
    output logic   out_valid,
    input  logic   out_ready,
    output entry_t out_data
);
    localparam int DEPTH = `NDN_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    entry_t            fifo_mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  count_nxt;
    logic              push;
    logic              pop;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_data = fifo_mem[rd_ptr];

    always_comb begin
        case ({push, pop})
            2'b10:   count_nxt = count + 1'b1;
            2'b01:   count_nxt = count - 1'b1;
            default: count_nxt = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count_nxt;
            // Ready follows the occupancy after this edge
            in_ready <= (count_nxt < FULL_CNT);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= in_data;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= FULL_CNT
    ) else $error("queue count above depth");

endmodule

`default_nettype wire

//--- rtl/fib_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serves one insert or one lookup at a time
// Inserts win over lookups when both are waiting
// Insert is 3 cycles, each lookup probe is 3 cycles
// Nothing is popped while clear_busy or a result is held
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fib_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              clear_busy,
    input  logic              ins_valid,
    output logic              ins_ready,
    input  ndn_pkg::fib_key_t ins_data,
    input  logic              lkp_valid,
    output logic              lkp_ready,
    input  ndn_pkg::fib_lkp_t lkp_data,
    output ndn_pkg::prefix_t  hash_prefix,
    output ndn_pkg::len_t     hash_len,
    input  ndn_pkg::hash_t    hash_value,
    input  ndn_pkg::prefix_t  masked_prefix,
    output logic              wr_en,
    output ndn_pkg::len_t     wr_len,
    output ndn_pkg::hash_t    wr_hash,
    output logic              rd_en,
    output ndn_pkg::len_t     rd_len,
    output ndn_pkg::hash_t    rd_hash,
    input  logic              rd_bit,
    output logic              res_valid,
    input  logic              res_ready,
    output logic              res_hit,
    output ndn_pkg::len_t     res_len,
    output ndn_pkg::prefix_t  res_prefix,
    output ndn_pkg::tag_t     res_tag
);
    import ndn_pkg::*;

    typedef enum logic [2:0] {
        idle,
        ins_hash,
        ins_write,
        lkp_hash,
        lkp_read,
        lkp_decide,
        result
    } state_t;

    state_t  state;
    prefix_t cur_prefix;
    len_t    cur_len;
    tag_t    cur_tag;
    logic    ins_pop;
    logic    lkp_pop;
    logic    probe_done;

    // Pops only from idle once the sweep is over, insert first
    assign ins_ready = (state == idle) && !clear_busy;
    assign lkp_ready = (state == idle) && !clear_busy && !ins_valid;
    assign ins_pop = ins_valid && ins_ready;
    assign lkp_pop = lkp_valid && lkp_ready;

    // Hash unit sees the held request, stable through read and decide
    assign hash_prefix = cur_prefix;
    assign hash_len = cur_len;

    assign wr_en = (state == ins_write);
    assign wr_len = cur_len;
    assign wr_hash = hash_value;
    assign rd_en = (state == lkp_read);
    assign rd_len = cur_len;
    assign rd_hash = hash_value;
    assign res_valid = (state == result);

    // Stop on a hit or after the miss at length 0
    assign probe_done = rd_bit || (cur_len == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (ins_pop) begin
                        state <= ins_hash;
                    end else if (lkp_pop) begin
                        state <= lkp_hash;
                    end
                end
                ins_hash:   state <= ins_write;
                ins_write:  state <= idle;
                lkp_hash:   state <= lkp_read;
                lkp_read:   state <= lkp_decide;
                lkp_decide: state <= probe_done ? result : lkp_hash;
                result: begin
                    if (res_ready) begin
                        state <= idle;
                    end
                end
                default:    state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ins_pop) begin
            cur_prefix <= ins_data.prefix;
            cur_len    <= ins_data.len;
        end else if (lkp_pop) begin
            cur_prefix <= lkp_data.prefix;
            cur_len    <= lkp_data.len;
            cur_tag    <= lkp_data.tag;
        end
        if (state == lkp_decide) begin
            if (rd_bit) begin
                res_hit    <= 1'b1;
                res_len    <= cur_len;
                res_prefix <= masked_prefix;
                res_tag    <= cur_tag;
            end else if (cur_len == '0) begin
                // Nothing matched, not even the default route
                res_hit    <= 1'b0;
                res_len    <= '0;
                res_prefix <= '0;
                res_tag    <= cur_tag;
            end else begin
                cur_len <= cur_len - 1'b1;
            end
        end
    end

    a_res_stable: assert property (
        @(posedge clk) disable iff (rst)
        (res_valid && !res_ready) |=> (res_valid && $stable(res_hit) && $stable(res_len)
            && $stable(res_prefix) && $stable(res_tag))
    ) else $error("result changed while stalled");

endmodule

`default_nettype wire

//--- rtl/fib_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FIB top level with insert, lookup and result ports
// Requests are accepted before init_done but not served
// Lookup latency varies with probe count, see res_valid
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fib_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             ins_valid,
    output logic             ins_ready,
    input  ndn_pkg::prefix_t ins_prefix,
    input  ndn_pkg::len_t    ins_len,
    input  logic             lkp_valid,
    output logic             lkp_ready,
    input  ndn_pkg::prefix_t lkp_prefix,
    input  ndn_pkg::len_t    lkp_len,
    input  ndn_pkg::tag_t    lkp_tag,
    output logic             res_valid,
    input  logic             res_ready,
    output logic             res_hit,
    output ndn_pkg::len_t    res_len,
    output ndn_pkg::prefix_t res_prefix,
    output ndn_pkg::tag_t    res_tag,
    output logic             init_done
);
    import ndn_pkg::*;

    fib_key_t ins_entry;
    fib_key_t ins_head;
    fib_lkp_t lkp_entry;
    fib_lkp_t lkp_head;
    logic     ins_head_valid;
    logic     ins_head_ready;
    logic     lkp_head_valid;
    logic     lkp_head_ready;
    prefix_t  hash_prefix;
    len_t     hash_len;
    hash_t    hash_value;
    prefix_t  masked_prefix;
    logic     wr_en;
    len_t     wr_len;
    hash_t    wr_hash;
    logic     rd_en;
    len_t     rd_len;
    hash_t    rd_hash;
    logic     rd_bit;
    logic     clear_busy;

    // Loose ports into queue entries
    assign ins_entry = '{prefix: ins_prefix, len: ins_len};
    assign lkp_entry = '{prefix: lkp_prefix, len: lkp_len, tag: lkp_tag};
    assign init_done = ~clear_busy;

    req_fifo #(.entry_t(fib_key_t)) ins_fifo_inst (
        .clk(clk), .rst(rst),
        .in_valid(ins_valid), .in_ready(ins_ready), .in_data(ins_entry),
        .out_valid(ins_head_valid), .out_ready(ins_head_ready), .out_data(ins_head)
    );

    req_fifo #(.entry_t(fib_lkp_t)) lkp_fifo_inst (
        .clk(clk), .rst(rst),
        .in_valid(lkp_valid), .in_ready(lkp_ready), .in_data(lkp_entry),
        .out_valid(lkp_head_valid), .out_ready(lkp_head_ready), .out_data(lkp_head)
    );

    // Shared by both paths, insert and lookup never overlap
    prefix_hash prefix_hash_inst (
        .clk(clk), .rst(rst),
        .hash_prefix(hash_prefix), .hash_len(hash_len),
        .hash_value(hash_value), .masked_prefix(masked_prefix)
    );

    fib_valid_table fib_valid_table_inst (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_len(wr_len), .wr_hash(wr_hash),
        .rd_en(rd_en), .rd_len(rd_len), .rd_hash(rd_hash),
        .rd_bit(rd_bit), .clear_busy(clear_busy)
    );

    fib_ctrl fib_ctrl_inst (
        .clk(clk), .rst(rst), .clear_busy(clear_busy),
        .ins_valid(ins_head_valid), .ins_ready(ins_head_ready), .ins_data(ins_head),
        .lkp_valid(lkp_head_valid), .lkp_ready(lkp_head_ready), .lkp_data(lkp_head),
        .hash_prefix(hash_prefix), .hash_len(hash_len),
        .hash_value(hash_value), .masked_prefix(masked_prefix),
        .wr_en(wr_en), .wr_len(wr_len), .wr_hash(wr_hash),
        .rd_en(rd_en), .rd_len(rd_len), .rd_hash(rd_hash), .rd_bit(rd_bit),
        .res_valid(res_valid), .res_ready(res_ready), .res_hit(res_hit),
        .res_len(res_len), .res_prefix(res_prefix), .res_tag(res_tag)
    );

endmodule

`default_nettype wire

//--- sim/fib_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for fib_top
// Lookups wait for their result except in the queued backpressure test
// Model keeps (length, hash) pairs and aliases like the DUT
// A watchdog bounds the run length
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fib_tb;
    import ndn_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int CLEAR_CYCLES = 16384;
    localparam int N_RANDOM = 200;
    // Directed ops 4 + 2 + 8 + 4 before the random mix
    localparam int N_OPS = 18 + N_RANDOM;
    localparam int OP_CYCLES = 3 * 64 + 50;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + CLEAR_CYCLES + N_OPS * OP_CYCLES;

    logic    clk;
    logic    rst;
    logic    ins_valid;
    logic    ins_ready;
    prefix_t ins_prefix;
    len_t    ins_len;
    logic    lkp_valid;
    logic    lkp_ready;
    prefix_t lkp_prefix;
    len_t    lkp_len;
    tag_t    lkp_tag;
    logic    res_valid;
    logic    res_ready;
    logic    res_hit;
    len_t    res_len;
    prefix_t res_prefix;
    tag_t    res_tag;
    logic    init_done;

    integer  seed;
    // One bit per (length, hash) pair that has been inserted
    bit      model_set [64][256];
    prefix_t pool [4];

    fib_top fib_top_inst (
        .clk(clk), .rst(rst),
        .ins_valid(ins_valid), .ins_ready(ins_ready),
        .ins_prefix(ins_prefix), .ins_len(ins_len),
        .lkp_valid(lkp_valid), .lkp_ready(lkp_ready),
        .lkp_prefix(lkp_prefix), .lkp_len(lkp_len), .lkp_tag(lkp_tag),
        .res_valid(res_valid), .res_ready(res_ready), .res_hit(res_hit),
        .res_len(res_len), .res_prefix(res_prefix), .res_tag(res_tag),
        .init_done(init_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("Timeout: the tests did not finish within the cycle budget");
    end

    // Inputs change and outputs are sampled 1 ns after each edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_result(input logic exp_hit, input len_t exp_len,
                                input prefix_t exp_prefix, input tag_t exp_tag);
        check_flag("res_hit", res_hit, exp_hit);
        if (res_len !== exp_len) begin
            report_failure($sformatf("Mismatch res_len: got 0x%h expected 0x%h",
                                     res_len, exp_len));
        end
        if (res_prefix !== exp_prefix) begin
            report_failure($sformatf("Mismatch res_prefix: got 0x%h expected 0x%h",
                                     res_prefix, exp_prefix));
        end
        if (res_tag !== exp_tag) begin
            report_failure($sformatf("Mismatch res_tag: got 0x%h expected 0x%h",
                                     res_tag, exp_tag));
        end
    endtask

    // Leading len bits kept
    // Bit 63 is the first name bit
    function automatic prefix_t mask_prefix(input prefix_t p, input len_t l);
        prefix_t m;
        m = '0;
        for (int i = 0; i < 64; i++) begin
            if (i < int'(l)) begin
                m[63-i] = p[63-i];
            end
        end
        return m;
    endfunction

    // Byte fold of the masked prefix seeded with the length
    function automatic hash_t hash_of(input prefix_t m, input len_t l);
        hash_t h;
        h = hash_t'(l);
        for (int b = 0; b < 8; b++) begin
            h = h ^ m[b*8 +: 8];
        end
        return h;
    endfunction

    // Longest inserted length at or below l
    // A miss gives all zeros
    function automatic void model_match(input prefix_t p, input len_t l, output logic hit,
                                        output len_t ml, output prefix_t mp);
        prefix_t m;
        hit = 1'b0;
        ml = '0;
        mp = '0;
        for (int k = int'(l); k >= 0; k--) begin
            m = mask_prefix(p, len_t'(k));
            if (!hit && model_set[k][hash_of(m, len_t'(k))]) begin
                hit = 1'b1;
                ml = len_t'(k);
                mp = m;
            end
        end
    endfunction

    task automatic insert_prefix(input prefix_t p, input len_t l);
        ins_valid = 1'b1;
        ins_prefix = p;
        ins_len = l;
        while (!ins_ready) next_cycle();
        next_cycle();
        ins_valid = 1'b0;
        // Accepted now so every later lookup sees it
        model_set[l][hash_of(mask_prefix(p, l), l)] = 1'b1;
    endtask

    task automatic push_lookup(input prefix_t p, input len_t l, input tag_t t);
        lkp_valid = 1'b1;
        lkp_prefix = p;
        lkp_len = l;
        lkp_tag = t;
        while (!lkp_ready) next_cycle();
        next_cycle();
        lkp_valid = 1'b0;
    endtask

    // Toggle mode stalls each result for at least one cycle
    // Stall length is random and every stalled cycle is rechecked
    task automatic collect_result(input logic e_hit, input len_t e_len, input prefix_t e_pfx,
                                  input tag_t e_tag, input bit toggle);
        logic [31:0] r;
        while (!res_valid) next_cycle();
        check_result(e_hit, e_len, e_pfx, e_tag);
        res_ready = !toggle;
        while (!res_ready) begin
            next_cycle();
            check_flag("res_valid", res_valid, 1'b1);
            check_result(e_hit, e_len, e_pfx, e_tag);
            r = $random(seed);
            res_ready = r[0];
        end
        next_cycle();
    endtask

    task automatic lookup_check(input prefix_t p, input len_t l, input tag_t t);
        logic    e_hit;
        len_t    e_len;
        prefix_t e_pfx;
        model_match(p, l, e_hit, e_len, e_pfx);
        push_lookup(p, l, t);
        collect_result(e_hit, e_len, e_pfx, t, 1'b0);
    endtask

    task automatic reset_and_init();
        int cycles;
        cycles = 0;
        repeat (RESET_CYCLES) begin
            next_cycle();
            check_flag("res_valid", res_valid, 1'b0);
            check_flag("ins_ready", ins_ready, 1'b0);
            check_flag("lkp_ready", lkp_ready, 1'b0);
        end
        rst = 1'b0;
        check_flag("init_done", init_done, 1'b0);
        while (!init_done) begin
            check_flag("res_valid", res_valid, 1'b0);
            if (cycles > CLEAR_CYCLES + 4) begin
                report_failure("init_done did not rise within the clear sweep bound");
            end
            next_cycle();
            cycles++;
        end
        check_flag("ins_ready", ins_ready, 1'b1);
        check_flag("lkp_ready", lkp_ready, 1'b1);
    endtask

    task automatic miss_on_empty();
        lookup_check(64'hDEAD_BEEF_0000_1111, 6'd0, 4'd1);
        lookup_check(64'hDEAD_BEEF_0000_1111, 6'd7, 4'd2);
        lookup_check(64'h1234_0000_FFFF_0000, 6'd32, 4'd3);
        lookup_check(64'hFFFF_FFFF_FFFF_FFFF, 6'd63, 4'd4);
    endtask

    task automatic exact_match();
        insert_prefix(64'h0123_4567_89AB_CDEF, 6'd40);
        lookup_check(64'h0123_4567_89AB_CDEF, 6'd40, 4'd9);
    endtask

    task automatic longest_prefix();
        prefix_t p;
        p = 64'hC0A8_1234_5678_9ABC;
        insert_prefix(p, 6'd8);
        insert_prefix(p, 6'd16);
        insert_prefix(p, 6'd24);
        lookup_check(p, 6'd32, 4'd1);
        lookup_check(p, 6'd20, 4'd2);
        lookup_check(p, 6'd5, 4'd3);
        // Bits past length 24 differ and still hit at 24
        lookup_check(p ^ 64'h0000_00FF_FFFF_FFFF, 6'd40, 4'd4);
        lookup_check(p ^ 64'h0000_0000_0000_FFFF, 6'd63, 4'd5);
    endtask

    task automatic backpressure_order();
        prefix_t p [4];
        len_t    l [4];
        logic    e_hit [4];
        len_t    e_len [4];
        prefix_t e_pfx [4];
        p[0] = 64'hC0A8_1234_5678_9ABC;
        p[1] = 64'hC0A8_1200_0000_0000;
        p[2] = 64'hC0A8_FFFF_0000_0000;
        p[3] = 64'h0123_4567_89AB_CDEF;
        l[0] = 6'd32;
        l[1] = 6'd20;
        l[2] = 6'd12;
        l[3] = 6'd63;
        // First result parks in the controller while the rest queue up
        res_ready = 1'b0;
        for (int i = 0; i < 4; i++) begin
            model_match(p[i], l[i], e_hit[i], e_len[i], e_pfx[i]);
            push_lookup(p[i], l[i], tag_t'(10 + i));
        end
        for (int i = 0; i < 4; i++) begin
            collect_result(e_hit[i], e_len[i], e_pfx[i], tag_t'(10 + i), 1'b1);
        end
        res_ready = 1'b1;
    endtask

    task automatic random_mix();
        logic [31:0] r;
        prefix_t     p;
        for (int i = 0; i < 4; i++) begin
            pool[i] = {$random(seed), $random(seed)};
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            r = $random(seed);
            p = pool[r[1:0]];
            if (r[4:2] < 3'd3) begin
                insert_prefix(p, r[13:8]);
            end else begin
                // Sometimes disturb the low bits to exercise the masking
                if (r[5]) begin
                    p = p ^ {48'h0, r[31:16]};
                end
                lookup_check(p, r[13:8], r[7:4]);
            end
        end
    endtask

    initial begin
        seed = 32'ha0541080;
        rst = 1'b1;
        ins_valid = 1'b0;
        ins_prefix = '0;
        ins_len = '0;
        lkp_valid = 1'b0;
        lkp_prefix = '0;
        lkp_len = '0;
        lkp_tag = '0;
        res_ready = 1'b1;
        reset_and_init();
        miss_on_empty();
        exact_match();
        longest_prefix();
        backpressure_order();
        random_mix();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+rtl
rtl/ndn_pkg.sv
rtl/prefix_hash.sv
rtl/fib_valid_table.sv
rtl/req_fifo.sv
rtl/fib_ctrl.sv
rtl/fib_top.sv
sim/fib_tb.sv

//--- Makefile
# Verilator flow for the FIB testbench
# Any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
TOP        ?= fib_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= sim passed
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides, a run that stops early leaves no pass line
sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Run failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
